/* dv/simd_mul_assert.sv */
////////////////////////////////////////////////////////////
// Protocol assertions of the multiplier: reset state,
// start-to-valid latency and result hold under back-pressure
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module simd_mul_assert import simd_mul_pkg::*; (
  input logic    clk_i,
  input logic    rst_ni,
  input logic    start_i,
  input mul_op_e op_i,
  input logic    ready_i,
  input logic    valid_i,
  input data_t   result_i,
  input logic    ov_i,
  input logic    busy_i
);

  int   violations = 0;
  logic wide_op;
  logic take_lane, take_wide;

  assign wide_op   = op_i inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
  assign take_lane = start_i && !busy_i && !wide_op;
  assign take_wide = start_i && !busy_i && wide_op;

  ////////////////////////////////////////////////////////////
  // Reset and latency
  ////////////////////////////////////////////////////////////
  reset_idle: assert property (@(posedge clk_i)
    !rst_ni |=> !valid_i && !busy_i && !ov_i)
    else begin
      $error("outputs not idle after reset");
      violations++;
    end

  lane_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    take_lane |=> !valid_i ##1 valid_i)
    else begin
      $error("lane op valid not one cycle after start");
      violations++;
    end

  wide_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    take_wide |=> !valid_i ##1 !valid_i ##1 valid_i)
    else begin
      $error("32x32 op valid not two cycles after start");
      violations++;
    end

  // Valid only ever follows an accepted start
  no_spurious_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(valid_i) |-> $past(take_lane, 2) || $past(take_wide, 3))
    else begin
      $error("valid rose without an accepted start");
      violations++;
    end

  ////////////////////////////////////////////////////////////
  // Back-pressure
  ////////////////////////////////////////////////////////////
  result_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i && !ready_i |=> valid_i && busy_i && $stable(result_i) && $stable(ov_i))
    else begin
      $error("result not held while ready is low");
      violations++;
    end

  busy_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i && ready_i |=> !busy_i)
    else begin
      $error("busy still high after the result was taken");
      violations++;
    end

endmodule

`default_nettype wire

/* dv/simd_mul_tb.sv */
////////////////////////////////////////////////////////////
// Testbench of the SIMD fractional multiplier: clock, reset,
// LFSR stimulus, reference model and result checks
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "simd_mul_settings.svh"

module simd_mul_tb import simd_mul_pkg::*; ();

  localparam int unsigned NumItems = 64;
  localparam int unsigned MaxWait  = 20;
  localparam logic [15:0] Seed     = 16'd24241;

  logic        clk;
  logic        rst_n;
  logic        start;
  mul_req_t    req;
  logic        ready;
  logic        valid;
  data_t       result;
  logic        ov;
  logic        busy;
  logic [15:0] lfsr_state;

  simd_mul_top simd_mul_top_inst (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .start_i  (start),
    .req_i    (req),
    .ready_i  (ready),
    .valid_o  (valid),
    .result_o (result),
    .ov_o     (ov),
    .busy_o   (busy)
  );

  bind simd_mul_top simd_mul_assert assert_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_i),
    .op_i     (req_i.op),
    .ready_i  (ready_i),
    .valid_i  (valid_o),
    .result_i (result_o),
    .ov_i     (ov_o),
    .busy_i   (busy_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output data_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[`SIMD_MUL_XLEN-2:0], lfsr_state[0]};
    end
  endtask

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  // Most negative value in every lane of the op
  function automatic data_t min_operand(input mul_op_e op);
    case (op)
      OP_KHM8, OP_KHMX8:   return 32'h8080_8080;
      OP_KHM16, OP_KHMX16: return 32'h8000_8000;
      default:             return 32'h8000_0000;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  function automatic data_t model_result(input mul_op_e op, input data_t a, input data_t b,
                                         output logic ov);
    logic               crossed;
    byte_t              ab, bb;
    half_t              ah, bh;
    logic signed [15:0] p8;
    logic signed [31:0] p16;
    logic [63:0]        ea, eb, p64;
    data_t              r;
    crossed = (op == OP_KHMX8) || (op == OP_KHMX16);
    ov      = 1'b0;
    r       = '0;
    case (op)
      OP_KHM8, OP_KHMX8: begin
        for (int i = 0; i < 4; i++) begin
          ab = a[8*i +: 8];
          bb = crossed ? b[8*(i^1) +: 8] : b[8*i +: 8];
          p8 = $signed(ab) * $signed(bb);
          if ((ab == 8'h80) && (bb == 8'h80)) begin
            r[8*i +: 8] = 8'h7f;
            ov = 1'b1;
          end else begin
            r[8*i +: 8] = p8[14:7];
          end
        end
      end
      OP_KHM16, OP_KHMX16: begin
        for (int i = 0; i < 2; i++) begin
          ah  = a[16*i +: 16];
          bh  = crossed ? b[16*(i^1) +: 16] : b[16*i +: 16];
          p16 = $signed(ah) * $signed(bh);
          if ((ah == 16'h8000) && (bh == 16'h8000)) begin
            r[16*i +: 16] = 16'h7fff;
            ov = 1'b1;
          end else begin
            r[16*i +: 16] = p16[30:15];
          end
        end
      end
      default: begin
        ea = {32'b0, a};
        eb = {32'b0, b};
        if ((op == OP_MULH) || (op == OP_MULHSU)) begin
          ea = {{32{a[31]}}, a};
        end
        if (op == OP_MULH) begin
          eb = {{32{b[31]}}, b};
        end
        p64 = ea * eb;
        r   = (op == OP_MUL) ? p64[31:0] : p64[63:32];
      end
    endcase
    return r;
  endfunction

  task automatic check_outputs(input mul_op_e op, input data_t exp_res, input logic exp_ov);
    assert (result == exp_res) else begin
      fail_run($sformatf("CHECK FAILED %s result expected %08h actual %08h",
                         op.name(), exp_res, result));
    end
    assert (ov == exp_ov) else begin
      fail_run($sformatf("CHECK FAILED %s ov expected %0b actual %0b", op.name(), exp_ov, ov));
    end
  endtask

  task automatic check_protocol();
    assert (simd_mul_top_inst.assert_inst.violations == 0) else begin
      fail_run("a bound protocol assertion failed");
    end
  endtask

  task automatic run_item(input mul_op_e op, input data_t a, input data_t b);
    data_t exp_res;
    logic  exp_ov;
    data_t hold;
    int    waited;
    exp_res = model_result(op, a, b, exp_ov);
    draw_bits(2, hold);
    @(posedge clk);
    #1;
    start = 1'b1;
    req   = '{op: op, a: a, b: b};
    @(posedge clk);
    #1;
    start  = 1'b0;
    waited = 0;
    while (!valid && (waited < MaxWait)) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!valid) begin
      fail_run($sformatf("no valid result for %s within %0d cycles", op.name(), MaxWait));
    end
    check_outputs(op, exp_res, exp_ov);
    // Back-pressure for a few cycles
    repeat (hold[1:0]) begin
      @(posedge clk);
      #1;
    end
    check_outputs(op, exp_res, exp_ov);
    ready = 1'b1;
    @(posedge clk);
    #1;
    ready  = 1'b0;
    waited = 0;
    while (busy && (waited < MaxWait)) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (busy) begin
      fail_run($sformatf("unit stayed busy after %s result was taken", op.name()));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  initial begin
    data_t   a;
    data_t   b;
    mul_op_e op;
    rst_n      = 1'b0;
    start      = 1'b0;
    req        = '0;
    ready      = 1'b0;
    lfsr_state = Seed;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    assert ({valid, busy, ov} == 3'b000) else begin
      fail_run($sformatf("CHECK FAILED reset valid/busy/ov expected 000 actual %03b",
                         {valid, busy, ov}));
    end
    for (int i = 0; i < NumItems; i++) begin
      op = mul_op_e'(i % 8);
      draw_bits(`SIMD_MUL_XLEN, a);
      draw_bits(`SIMD_MUL_XLEN, b);
      // Corner rounds: all lanes most negative, then a zero operand
      if (((i / 8) % 4) == 1) begin
        a = min_operand(op);
        b = a;
      end else if (((i / 8) % 4) == 2) begin
        a = '0;
      end
      run_item(op, a, b);
      check_protocol();
    end
    repeat (3) @(posedge clk);
    if (simd_mul_top_inst.assert_inst.violations == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      fail_run("a bound protocol assertion failed");
    end
  end

endmodule

`default_nettype wire

/* logic/mul_kernel_array.sv */
////////////////////////////////////////////////////////////
// Kernel array: eight signed 9x9 products, the two 16x16
// kernel adders and the 32x16 adder
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "simd_mul_settings.svh"

module mul_kernel_array import simd_mul_pkg::*; (
  input  lane_ops_t    lanes_i,
  input  logic         low_word_i,
  output kernel_sums_t sums_o
);

  // 16x16 sum plus headroom for the unsigned case
  localparam int unsigned SumW = `SIMD_MUL_XLEN + 2;
  localparam int unsigned ExtW = $bits(part_t) - SumW;

  logic signed [SumW-1:0] k0_full, k1_full;
  part_t                  k0_term, k1_term;

  // One 8x8 kernel, the sign bit is the ninth operand bit
  function automatic prod_t kmul(input byte_t a, input logic sa, input byte_t b,
                                 input logic sb);
    logic signed [`SIMD_MUL_PROD_W-1:0] x;
    logic signed [`SIMD_MUL_PROD_W-1:0] y;
    x = $signed({sa, a});
    y = $signed({sb, b});
    return x * y;
  endfunction

  // Combines the four products of one kernel into a 16x16 product
  function automatic logic signed [SumW-1:0] ksum(input prod_t p00, input prod_t p01,
                                                   input prod_t p10, input prod_t p11);
    logic signed [SumW-1:0] hi;
    logic signed [SumW-1:0] mid;
    logic signed [SumW-1:0] lo;
    hi  = $signed(p11);
    mid = $signed(p01);
    mid = mid + $signed(p10);
    lo  = $signed(p00);
    return (hi <<< `SIMD_MUL_HALF_W) + (mid <<< `SIMD_MUL_BYTE_W) + lo;
  endfunction

  always_comb begin
    // Kernel 0
    sums_o.p0_00 = kmul(lanes_i.a0, lanes_i.a_signs[0], lanes_i.b0, lanes_i.b_signs[0]);
    sums_o.p0_01 = kmul(lanes_i.a0, lanes_i.a_signs[0], lanes_i.b1, lanes_i.b_signs[1]);
    sums_o.p0_10 = kmul(lanes_i.a1, lanes_i.a_signs[1], lanes_i.b0, lanes_i.b_signs[0]);
    sums_o.p0_11 = kmul(lanes_i.a1, lanes_i.a_signs[1], lanes_i.b1, lanes_i.b_signs[1]);
    // Kernel 1
    sums_o.p1_00 = kmul(lanes_i.a2, lanes_i.a_signs[2], lanes_i.b2, lanes_i.b_signs[2]);
    sums_o.p1_01 = kmul(lanes_i.a2, lanes_i.a_signs[2], lanes_i.b3, lanes_i.b_signs[3]);
    sums_o.p1_10 = kmul(lanes_i.a3, lanes_i.a_signs[3], lanes_i.b2, lanes_i.b_signs[2]);
    sums_o.p1_11 = kmul(lanes_i.a3, lanes_i.a_signs[3], lanes_i.b3, lanes_i.b_signs[3]);

    k0_full = ksum(sums_o.p0_00, sums_o.p0_01, sums_o.p0_10, sums_o.p0_11);
    k1_full = ksum(sums_o.p1_00, sums_o.p1_01, sums_o.p1_10, sums_o.p1_11);

    sums_o.sum16_0 = k0_full[`SIMD_MUL_XLEN-1:0];
    sums_o.sum16_1 = k1_full[`SIMD_MUL_XLEN-1:0];

    // Upper kernel shifted by a half word, lower one sign extended
    // unless only the low word is wanted
    k1_term = {k1_full[`SIMD_MUL_XLEN-1:0], {`SIMD_MUL_HALF_W{1'b0}}};
    k0_term = {{ExtW{k0_full[SumW-1] & ~low_word_i}}, k0_full};
    sums_o.sum_32x16 = k1_term + k0_term;
  end

endmodule

`default_nettype wire

/* logic/mul_operand_router.sv */
////////////////////////////////////////////////////////////
// Operand router: op decode into mode and signedness,
// quadrant selection of b and the kernel sign bits
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module mul_operand_router import simd_mul_pkg::*; (
  input  mul_req_t  req_i,
  input  logic      upper_pass_i,
  output mul_mode_e mode_o,
  output logic      crossed_o,
  output logic      low_word_o,
  output lane_ops_t lanes_o
);

  logic       signed_a, signed_b;
  logic [1:0] quadrant;
  half_t      ker0_b, ker1_b;
  logic [3:0] a_msbs, b_msbs;
  logic [3:0] a_mask, b_mask;

  // Op decode
  always_comb begin
    mode_o    = M8x8;
    crossed_o = 1'b0;
    signed_a  = 1'b1;
    signed_b  = 1'b1;
    unique case (req_i.op)
      OP_KHMX8: begin
        crossed_o = 1'b1;
      end
      OP_KHM16: begin
        mode_o = M16x16;
      end
      OP_KHMX16: begin
        mode_o    = M16x16;
        crossed_o = 1'b1;
      end
      OP_MULH: begin
        mode_o = M32x32;
      end
      OP_MULHSU: begin
        mode_o   = M32x32;
        signed_b = 1'b0;
      end
      OP_MUL,
      OP_MULHU: begin
        mode_o   = M32x32;
        signed_a = 1'b0;
        signed_b = 1'b0;
      end
      default: begin
        mode_o = M8x8;
      end
    endcase
  end

  // Only mul keeps the low word of the product
  assign low_word_o = (req_i.op == OP_MUL);

  // Bit 0 moves b's upper half to kernel 0, bit 1 the lower half to kernel 1
  always_comb begin
    unique case (mode_o)
      M16x16:  quadrant = crossed_o ? 2'b11 : 2'b00;
      M32x32:  quadrant = upper_pass_i ? 2'b01 : 2'b10;
      default: quadrant = 2'b00;
    endcase
  end

  assign ker0_b = quadrant[0] ? req_i.b[31:16] : req_i.b[15:0];
  assign ker1_b = quadrant[1] ? req_i.b[15:0] : req_i.b[31:16];

  ////////////////////////////////////////////////////////////
  // Sign decoder
  ////////////////////////////////////////////////////////////
  assign a_msbs = {req_i.a[31], req_i.a[23], req_i.a[15], req_i.a[7]};
  assign b_msbs = {ker1_b[15], ker1_b[7], ker0_b[15], ker0_b[7]};

  // Sign bits sit on the top byte of each lane
  always_comb begin
    unique case (mode_o)
      M16x16: begin
        a_mask = {signed_a, 1'b0, signed_a, 1'b0};
        b_mask = {signed_b, 1'b0, signed_b, 1'b0};
      end
      M32x32: begin
        a_mask = {signed_a, 3'b000};
        b_mask = {signed_b & upper_pass_i, 1'b0, signed_b & upper_pass_i, 1'b0};
      end
      default: begin
        a_mask = {4{signed_a}};
        b_mask = {4{signed_b}};
      end
    endcase
  end

  assign lanes_o = '{
    a3:      req_i.a[31:24],
    a2:      req_i.a[23:16],
    a1:      req_i.a[15:8],
    a0:      req_i.a[7:0],
    b3:      ker1_b[15:8],
    b2:      ker1_b[7:0],
    b1:      ker0_b[15:8],
    b0:      ker0_b[7:0],
    a_signs: a_msbs & a_mask,
    b_signs: b_msbs & b_mask
  };

endmodule

`default_nettype wire

/* logic/mul_result_select.sv */
////////////////////////////////////////////////////////////
// Result select: lane saturation, Q7/Q15 extraction and
// the 32x32 upper-pass combine adder
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "simd_mul_settings.svh"

module mul_result_select import simd_mul_pkg::*; (
  input  mul_mode_e    mode_i,
  input  logic         crossed_i,
  input  mul_op_e      op_i,
  input  logic         upper_pass_i,
  input  lane_ops_t    lanes_i,
  input  kernel_sums_t sums_i,
  input  part_t        part_i,
  output data_t        result_o,
  output logic         ov_o
);

  localparam int unsigned Q7Lo  = `SIMD_MUL_BYTE_W - 1;
  localparam int unsigned Q7Hi  = 2 * `SIMD_MUL_BYTE_W - 2;
  localparam int unsigned Q15Lo = `SIMD_MUL_HALF_W - 1;
  localparam int unsigned Q15Hi = 2 * `SIMD_MUL_HALF_W - 2;
  localparam int unsigned PartW = $bits(part_t);

  localparam byte_t Q7Min  = 8'h80;
  localparam byte_t Q7Max  = 8'h7f;
  localparam half_t Q15Min = 16'h8000;
  localparam half_t Q15Max = 16'h7fff;

  prod_t [3:0] lane_p;
  byte_t [3:0] b_pair;
  byte_t [3:0] q7;
  half_t [1:0] q15;
  logic  [3:0] byte_sat;
  logic  [1:0] half_sat;
  logic        signed_a, low_word;
  part_t       comb_a, comb_b, comb_sum;

  ////////////////////////////////////////////////////////////
  // Saturation
  ////////////////////////////////////////////////////////////
  // Crossed Q7 lanes pair each a byte with its neighbour in b
  assign b_pair = crossed_i ? {lanes_i.b2, lanes_i.b3, lanes_i.b0, lanes_i.b1} :
                              {lanes_i.b3, lanes_i.b2, lanes_i.b1, lanes_i.b0};

  assign byte_sat[0] = (lanes_i.a0 == Q7Min) && (b_pair[0] == Q7Min);
  assign byte_sat[1] = (lanes_i.a1 == Q7Min) && (b_pair[1] == Q7Min);
  assign byte_sat[2] = (lanes_i.a2 == Q7Min) && (b_pair[2] == Q7Min);
  assign byte_sat[3] = (lanes_i.a3 == Q7Min) && (b_pair[3] == Q7Min);

  // Halves of b arrive already swapped for the crossed Q15 op
  assign half_sat[0] = ({lanes_i.a1, lanes_i.a0} == Q15Min) &&
                       ({lanes_i.b1, lanes_i.b0} == Q15Min);
  assign half_sat[1] = ({lanes_i.a3, lanes_i.a2} == Q15Min) &&
                       ({lanes_i.b3, lanes_i.b2} == Q15Min);

  // Lane results
  assign lane_p = crossed_i ? {sums_i.p1_10, sums_i.p1_01, sums_i.p0_10, sums_i.p0_01} :
                              {sums_i.p1_11, sums_i.p1_00, sums_i.p0_11, sums_i.p0_00};

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      q7[i] = byte_sat[i] ? Q7Max : lane_p[i][Q7Hi:Q7Lo];
    end
    q15[0] = half_sat[0] ? Q15Max : sums_i.sum16_0[Q15Hi:Q15Lo];
    q15[1] = half_sat[1] ? Q15Max : sums_i.sum16_1[Q15Hi:Q15Lo];
  end

  ////////////////////////////////////////////////////////////
  // 32x32 combine adder
  ////////////////////////////////////////////////////////////
  assign signed_a = (op_i == OP_MULH) || (op_i == OP_MULHSU);
  assign low_word = (op_i == OP_MUL);

  always_comb begin
    if (low_word) begin
      comb_a = {sums_i.sum_32x16[`SIMD_MUL_HALF_W-1:0], {`SIMD_MUL_XLEN{1'b0}}};
      comb_b = {part_i[`SIMD_MUL_XLEN-1:0], {`SIMD_MUL_HALF_W{1'b0}}};
    end else begin
      // Lower partial shifted down a half word
      comb_a = sums_i.sum_32x16;
      comb_b = {{`SIMD_MUL_HALF_W{part_i[PartW-1] & signed_a}},
                part_i[PartW-1:`SIMD_MUL_HALF_W]};
    end
  end

  assign comb_sum = comb_a + comb_b;

  // Final mux
  always_comb begin
    unique case (mode_i)
      M8x8: begin
        result_o = q7;
        ov_o     = |byte_sat;
      end
      M16x16: begin
        result_o = q15;
        ov_o     = |half_sat;
      end
      default: begin
        // Lower pass only shows the partial low word
        result_o = upper_pass_i ? comb_sum[PartW-1:`SIMD_MUL_HALF_W] :
                                  sums_i.sum_32x16[`SIMD_MUL_XLEN-1:0];
        ov_o     = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* logic/simd_mul_ctrl.sv */
////////////////////////////////////////////////////////////
// Multiplier controller: pass FSM, request, partial product
// and result registers, result hold under back-pressure
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module simd_mul_ctrl import simd_mul_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     start_i,
  input  mul_req_t req_i,
  input  logic     ready_i,
  input  part_t    part_i,
  input  data_t    result_i,
  input  logic     ov_i,
  output mul_req_t req_o,
  output logic     upper_pass_o,
  output part_t    part_o,
  output logic     valid_o,
  output data_t    result_o,
  output logic     ov_o,
  output logic     busy_o
);

  mul_state_e state_q, state_d;
  mul_req_t   req_q;
  part_t      part_q;
  data_t      result_q;
  logic       ov_q;
  logic       wide_op;
  logic       accept, finish;

  // 32x32 ops need the second pass
  assign wide_op = req_q.op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
  assign accept  = start_i && (state_q == IDLE);
  assign finish  = ((state_q == LOWER) && !wide_op) || (state_q == UPPER);

  ////////////////////////////////////////////////////////////
  // Pass FSM
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = LOWER;
        end
      end
      LOWER:   state_d = wide_op ? UPPER : DONE;
      UPPER:   state_d = DONE;
      DONE: begin
        // Hold until the consumer takes the result
        if (ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      ov_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (finish) begin
        ov_q <= ov_i;
      end
    end
  end

  // Request, lower partial and result
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
    if ((state_q == LOWER) && wide_op) begin
      part_q <= part_i;
    end
    if (finish) begin
      result_q <= result_i;
    end
  end

  assign req_o        = req_q;
  assign upper_pass_o = (state_q == UPPER);
  assign part_o       = part_q;
  assign valid_o      = (state_q == DONE);
  assign result_o     = result_q;
  assign ov_o         = ov_q;
  assign busy_o       = (state_q != IDLE);

endmodule

`default_nettype wire

/* logic/simd_mul_pkg.sv */
////////////////////////////////////////////////////////////
// Shared types of the multiplier: width typedefs, op, mode
// and state enums, request, lane operand and kernel sum
// structs
////////////////////////////////////////////////////////////

`default_nettype none

`include "simd_mul_settings.svh"

package simd_mul_pkg;

  typedef logic [`SIMD_MUL_XLEN-1:0]   data_t;
  typedef logic [`SIMD_MUL_BYTE_W-1:0] byte_t;
  typedef logic [`SIMD_MUL_HALF_W-1:0] half_t;
  typedef logic [`SIMD_MUL_PROD_W-1:0] prod_t;
  // 32x16 partial product
  typedef logic [`SIMD_MUL_XLEN+`SIMD_MUL_HALF_W-1:0] part_t;

  typedef enum logic [2:0] {
    OP_KHM8,
    OP_KHMX8,
    OP_KHM16,
    OP_KHMX16,
    OP_MUL,
    OP_MULH,
    OP_MULHSU,
    OP_MULHU
  } mul_op_e;

  typedef enum logic [1:0] {
    M8x8,
    M16x16,
    M32x32
  } mul_mode_e;

  typedef enum logic [1:0] {
    IDLE,
    LOWER,
    UPPER,
    DONE
  } mul_state_e;

  typedef struct packed {
    mul_op_e op;
    data_t   a;
    data_t   b;
  } mul_req_t;

  // Kernel 0 takes a0/a1 and b0/b1, kernel 1 takes a2/a3 and b2/b3
  typedef struct packed {
    byte_t      a3, a2, a1, a0;
    byte_t      b3, b2, b1, b0;
    logic [3:0] a_signs;
    logic [3:0] b_signs;
  } lane_ops_t;

  typedef struct packed {
    prod_t p0_00, p0_01, p0_10, p0_11;
    prod_t p1_00, p1_01, p1_10, p1_11;
    data_t sum16_0;
    data_t sum16_1;
    part_t sum_32x16;
  } kernel_sums_t;

endpackage

`default_nettype wire

/* logic/simd_mul_settings.svh */
////////////////////////////////////////////////////////////
// Width settings of the packed-SIMD fractional multiplier
////////////////////////////////////////////////////////////

`ifndef SIMD_MUL_SETTINGS_SVH
`define SIMD_MUL_SETTINGS_SVH

// Operand and result word
`define SIMD_MUL_XLEN   32

// Q7 and Q15 lane widths
`define SIMD_MUL_BYTE_W 8
`define SIMD_MUL_HALF_W 16

// Signed 9x9 kernel product
`define SIMD_MUL_PROD_W 18

`endif

/* logic/simd_mul_top.sv */
////////////////////////////////////////////////////////////
// Top level of the SIMD fractional multiplier
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module simd_mul_top import simd_mul_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     start_i,
  input  mul_req_t req_i,
  input  logic     ready_i,
  output logic     valid_o,
  output data_t    result_o,
  output logic     ov_o,
  output logic     busy_o
);

  mul_req_t     req_q;
  logic         upper_pass;
  part_t        part_q;
  mul_mode_e    mode;
  logic         crossed;
  logic         low_word;
  lane_ops_t    lanes;
  kernel_sums_t sums;
  data_t        sel_result;
  logic         sel_ov;

  simd_mul_ctrl ctrl_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .req_i        (req_i),
    .ready_i      (ready_i),
    .part_i       (sums.sum_32x16),
    .result_i     (sel_result),
    .ov_i         (sel_ov),
    .req_o        (req_q),
    .upper_pass_o (upper_pass),
    .part_o       (part_q),
    .valid_o      (valid_o),
    .result_o     (result_o),
    .ov_o         (ov_o),
    .busy_o       (busy_o)
  );

  mul_operand_router router_inst (
    .req_i        (req_q),
    .upper_pass_i (upper_pass),
    .mode_o       (mode),
    .crossed_o    (crossed),
    .low_word_o   (low_word),
    .lanes_o      (lanes)
  );

  mul_kernel_array kernel_inst (
    .lanes_i    (lanes),
    .low_word_i (low_word),
    .sums_o     (sums)
  );

  mul_result_select select_inst (
    .mode_i       (mode),
    .crossed_i    (crossed),
    .op_i         (req_q.op),
    .upper_pass_i (upper_pass),
    .lanes_i      (lanes),
    .sums_i       (sums),
    .part_i       (part_q),
    .result_o     (sel_result),
    .ov_o         (sel_ov)
  );

endmodule

`default_nettype wire

/* simd_mul_top.f */
+incdir+logic
logic/simd_mul_pkg.sv
logic/mul_operand_router.sv
logic/mul_kernel_array.sv
logic/mul_result_select.sv
logic/simd_mul_ctrl.sv
logic/simd_mul_top.sv
dv/simd_mul_assert.sv
dv/simd_mul_tb.sv
